// ==== vpu_core.f ====
common/vpu_pkg.sv
rtl/isa_decoder.sv
rtl/core_ctrl.sv
rtl/elem_counter.sv
rtl/scalar_unit/scalar_unit.sv
rtl/vector_lane/vector_lane.sv
rtl/vpu_core.sv
testbench/tb_clock_gen.sv
testbench/tb_vpu_core.sv

// ==== Makefile ====
TOP = tb_vpu_core

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f vpu_core.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f vpu_core.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "TESTBENCH PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== testbench/tb_vpu_core.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_vpu_core;
    import vpu_pkg::*;

    localparam int MAX_VL    = 8;
    localparam int RUN_LIMIT = 3000; // cycles per program
    localparam logic [31:0] WFI = 32'h1050_0073;

    logic            clk;
    logic            rst_n;
    logic            start;
    logic            done;
    logic            instr_req;
    logic [PC_W-1:0] instr_addr;
    logic [ILEN-1:0] instr;
    logic            instr_ack;
    logic            out_req;
    logic [XLEN-1:0] out_data;
    logic            out_ack;

    logic [31:0] prog [1024]; // whole 12-bit byte space
    int          prog_len;
    int          fetch_addrs [$];
    logic [31:0] stream_vals [$];
    logic [31:0] lfsr;
    int          errors;
    int          tests;
    bit          delay_on;
    int          wait_cnt;
    int          cur_delay;

    tb_clock_gen i_tb_clock_gen (.clk, .rst_n);

    vpu_core #(.MAX_VL(MAX_VL), .NUM_VREG(8)) i_vpu_core (
        .clk, .rst_n, .start, .done, .instr_req, .instr_addr, .instr, .instr_ack,
        .out_req, .out_data, .out_ack
    );

    // fibonacci taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] val;
        logic        fb;
        val = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            val  = {val[30:0], fb};
        end
        return val;
    endfunction

    function automatic logic [31:0] sext5(input logic [4:0] v);
        return {{27{v[4]}}, v};
    endfunction

    function automatic logic [31:0] enc_vsetivli(input logic [4:0] avl);
        return {2'b11, 10'd0, avl, 3'b111, 5'd0, 7'h57};
    endfunction

    function automatic logic [31:0] enc_vmv_vi(input logic [4:0] vd, input logic [4:0] simm);
        return {6'b010111, 1'b1, 5'd0, simm, 3'b101, vd, 7'h57};
    endfunction

    function automatic logic [31:0] enc_vmacc(input logic [4:0] vd, input logic [4:0] vs1,
                                              input logic [4:0] vs2);
        return {6'b101101, 1'b1, vs2, vs1, 3'b000, vd, 7'h57};
    endfunction

    function automatic logic [31:0] enc_vstream(input logic [4:0] vs);
        return {20'd0, vs, 7'h7f}; // source sits in the rd slot
    endfunction

    function automatic logic [31:0] enc_addi(input logic [4:0] rd, input logic [4:0] rs1,
                                             input logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, 7'h13};
    endfunction

    function automatic logic [31:0] enc_bne(input logic [4:0] rs1, input logic [4:0] rs2,
                                            input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, 3'b001, off[4:1], off[11], 7'h63};
    endfunction

    function automatic int next_delay();
        return delay_on ? int'(rand_bits(3)) : 0;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic clear_program();
        for (int i = 0; i < 1024; i++) begin
            prog[i] = enc_addi(5'd0, 5'd0, 12'(i)); // no-op tagged with its own index
        end
        prog_len = 0;
    endtask

    task automatic put_instr(input logic [31:0] w);
        prog[prog_len] = w;
        prog_len++;
    endtask

    task automatic serve_fetch();
        if (instr_req && !instr_ack) begin
            fetch_addrs.push_back(int'(instr_addr));
            instr     = prog[instr_addr[PC_W-1:2]];
            instr_ack = 1'b1;
        end else if (!instr_req && instr_ack) begin
            instr_ack = 1'b0;
        end
    endtask

    task automatic collect_stream();
        if (out_req && !out_ack) begin
            if (wait_cnt >= cur_delay) begin
                stream_vals.push_back(out_data);
                out_ack   = 1'b1;
                wait_cnt  = 0;
                cur_delay = next_delay();
            end else begin
                wait_cnt++; // host holding off
            end
        end else if (!out_req && out_ack) begin
            out_ack = 1'b0;
        end
    endtask

    task automatic run_program(input bit use_delay);
        int cycles;
        bit finished;
        fetch_addrs.delete();
        stream_vals.delete();
        delay_on  = use_delay;
        wait_cnt  = 0;
        cur_delay = next_delay();
        cycles    = 0;
        finished  = 1'b0;
        @(negedge clk);
        start = 1'b1;
        while (!finished && cycles < RUN_LIMIT) begin
            @(negedge clk);
            serve_fetch();
            collect_stream();
            if (done) finished = 1'b1;
            cycles++;
        end
        if (!finished) begin
            $display("timeout: done never rose within %0d cycles", RUN_LIMIT);
            errors++;
        end
        start  = 1'b0;
        cycles = 0;
        while (done && cycles < 20) begin
            @(negedge clk);
            cycles++;
        end
        if (done) begin
            $display("timeout: done stayed high after start was dropped");
            errors++;
        end
    endtask

    task automatic check_stream(input logic [31:0] exp, input int count);
        check_value("stream count", 32'(stream_vals.size()), 32'(count));
        for (int i = 0; i < count && i < stream_vals.size(); i++) begin
            check_value($sformatf("out_data[%0d]", i), stream_vals[i], exp);
        end
    endtask

    task automatic report_test(input string name, input int err0);
        tests++;
        $display("test %s: %s", name, (errors == err0) ? "ok" : "errors seen");
    endtask

    task automatic test_reset_wfi();
        int err0;
        err0 = errors;
        check_value("done", {31'b0, done}, 32'd0);
        check_value("instr_req", {31'b0, instr_req}, 32'd0);
        check_value("out_req", {31'b0, out_req}, 32'd0);
        clear_program();
        put_instr(WFI);
        run_program(1'b0);
        check_value("fetch count", 32'(fetch_addrs.size()), 32'd1);
        if (fetch_addrs.size() > 0) check_value("instr_addr", 32'(fetch_addrs[0]), 32'd0);
        report_test("reset_wfi", err0);
    endtask

    task automatic test_splat_stream();
        int          err0;
        logic [4:0]  simm;
        err0 = errors;
        simm = 5'(rand_bits(5));
        clear_program();
        put_instr(enc_vsetivli(5'd5));
        put_instr(enc_vmv_vi(5'd1, simm));
        put_instr(enc_vstream(5'd1));
        put_instr(WFI);
        run_program(1'b0);
        check_stream(sext5(simm), 5);
        report_test("splat_stream", err0);
    endtask

    task automatic test_vmacc();
        int          err0;
        logic [4:0]  a;
        logic [4:0]  b;
        logic [4:0]  c;
        logic [31:0] exp;
        err0 = errors;
        a    = 5'(rand_bits(5));
        b    = 5'(rand_bits(5));
        c    = 5'(rand_bits(5));
        exp  = sext5(c) + 32'd2 * sext5(a) * sext5(b); // two accumulations
        clear_program();
        put_instr(enc_vsetivli(5'(MAX_VL)));
        put_instr(enc_vmv_vi(5'd1, a));
        put_instr(enc_vmv_vi(5'd2, b));
        put_instr(enc_vmv_vi(5'd3, c));
        put_instr(enc_vmacc(5'd3, 5'd1, 5'd2));
        put_instr(enc_vmacc(5'd3, 5'd1, 5'd2));
        put_instr(enc_vstream(5'd3));
        put_instr(WFI);
        run_program(1'b0);
        check_stream(exp, MAX_VL);
        report_test("vmacc", err0);
    endtask

    task automatic test_vl_clamp();
        int err0;
        err0 = errors;
        clear_program();
        put_instr(enc_vsetivli(5'd0));
        put_instr(enc_vstream(5'd1));
        put_instr(WFI);
        run_program(1'b0);
        check_value("stream count avl 0", 32'(stream_vals.size()), 32'd1);
        clear_program();
        put_instr(enc_vsetivli(5'd31)); // above MAX_VL
        put_instr(enc_vstream(5'd1));
        put_instr(WFI);
        run_program(1'b0);
        check_value("stream count avl 31", 32'(stream_vals.size()), 32'(MAX_VL));
        report_test("vl_clamp", err0);
    endtask

    task automatic test_scalar_loop();
        int err0;
        int x1;
        int exp_addrs [$];
        err0 = errors;
        clear_program();
        put_instr(enc_addi(5'd1, 5'd0, 12'd3));
        put_instr(enc_addi(5'd1, 5'd1, 12'hfff));
        put_instr(enc_bne(5'd1, 5'd0, 13'h1ffc)); // back to the decrement
        put_instr(WFI);
        // fetch order of the countdown loop
        x1 = 3;
        exp_addrs.push_back(0);
        do begin
            exp_addrs.push_back(4);
            exp_addrs.push_back(8);
            x1--;
        end while (x1 != 0);
        exp_addrs.push_back(12);
        run_program(1'b0);
        check_value("fetch count", 32'(fetch_addrs.size()), 32'(exp_addrs.size()));
        for (int i = 0; i < exp_addrs.size() && i < fetch_addrs.size(); i++) begin
            check_value($sformatf("instr_addr[%0d]", i), 32'(fetch_addrs[i]),
                        32'(exp_addrs[i]));
        end
        report_test("scalar_loop", err0);
    endtask

    task automatic test_backpressure();
        int          err0;
        logic [4:0]  p;
        logic [4:0]  q;
        logic [31:0] exp;
        err0 = errors;
        p    = 5'(rand_bits(5));
        q    = ~p; // differs from p in every bit
        clear_program();
        put_instr(enc_vsetivli(5'(MAX_VL)));
        put_instr(enc_vmv_vi(5'd3, p));
        put_instr(enc_vsetivli(5'd3));
        put_instr(enc_vmv_vi(5'd3, q)); // overwrites elements 0..2 only
        put_instr(enc_vsetivli(5'(MAX_VL)));
        put_instr(enc_vstream(5'd3));
        put_instr(WFI);
        for (int d = 0; d < 2; d++) begin
            run_program(d == 1); // second pass holds ack off 0..7 cycles
            check_value("stream count", 32'(stream_vals.size()), 32'(MAX_VL));
            for (int i = 0; i < MAX_VL && i < stream_vals.size(); i++) begin
                exp = (i < 3) ? sext5(q) : sext5(p);
                check_value($sformatf("out_data[%0d]", i), stream_vals[i], exp);
            end
        end
        report_test("backpressure", err0);
    endtask

    initial begin
        int cycles;
        start     = 1'b0;
        instr     = '0;
        instr_ack = 1'b0;
        out_ack   = 1'b0;
        lfsr      = 32'h59031b6f;
        errors    = 0;
        tests     = 0;
        cycles    = 0;
        while (rst_n !== 1'b1 && cycles < 20) begin
            @(negedge clk);
            cycles++;
        end
        if (rst_n !== 1'b1) begin
            $display("timeout: reset was never released");
            errors++;
        end
        test_reset_wfi();
        test_splat_stream();
        test_vmacc();
        test_vl_clamp();
        test_scalar_loop();
        test_backpressure();
        $display("tests run: %0d, errors: %0d", tests, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== testbench/tb_clock_gen.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic rst_n
);
    initial clk = 1'b0;
    always #5 clk = ~clk; // 10 ns period

    initial begin
        rst_n = 1'b0;
        repeat (3) @(negedge clk); // covers three rising edges
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire

// ==== rtl/vpu_core.sv ====
`timescale 1ns/10ps
`default_nettype none

module vpu_core #(
    parameter int MAX_VL   = 8,
    parameter int NUM_VREG = 8
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     start,
    output logic                     done,
    output logic                     instr_req,
    output logic [vpu_pkg::PC_W-1:0] instr_addr,
    input  logic [vpu_pkg::ILEN-1:0] instr,
    input  logic                     instr_ack,
    output logic                     out_req,
    output logic [vpu_pkg::XLEN-1:0] out_data,
    input  logic                     out_ack
);
    import vpu_pkg::*;

    logic [ILEN-1:0]           ir;
    opcode_e                   opcode;
    logic [REG_AW-1:0]         rd;
    logic [REG_AW-1:0]         rs1;
    logic [REG_AW-1:0]         rs2;
    logic [XLEN-1:0]           imm;
    logic [PC_W-1:0]           branch_off;
    logic                      x_wen;
    logic                      v_step;
    logic                      vl_load;
    logic                      branch_taken;
    logic [$clog2(MAX_VL)-1:0] elem_idx;
    logic                      last_elem;
    logic [XLEN-1:0]           stream_data;

    core_ctrl i_core_ctrl (
        .clk, .rst_n, .start, .done, .instr_req, .instr_addr, .instr, .instr_ack,
        .out_req, .out_data, .out_ack, .ir, .opcode, .branch_off, .branch_taken,
        .last_elem, .stream_data, .x_wen, .v_step, .vl_load
    );

    isa_decoder i_isa_decoder (
        .instr(ir), .opcode, .rd, .rs1, .rs2, .imm, .branch_off
    );

    elem_counter #(.MAX_VL(MAX_VL)) i_elem_counter (
        .clk, .rst_n, .vl_load,
        .avl(imm[4:0]), // vsetivli uimm
        .v_step, .elem_idx, .last_elem
    );

    scalar_unit i_scalar_unit (
        .clk, .rst_n, .opcode, .rd, .rs1, .rs2, .imm, .x_wen, .branch_taken
    );

    vector_lane #(.MAX_VL(MAX_VL), .NUM_VREG(NUM_VREG)) i_vector_lane (
        .clk, .rst_n, .opcode, .rd, .rs1, .rs2, .imm, .v_step, .elem_idx, .stream_data
    );

endmodule

`default_nettype wire

// ==== rtl/vector_lane/vector_lane.sv ====
`timescale 1ns/10ps
`default_nettype none

module vector_lane #(
    parameter int MAX_VL   = 8,
    parameter int NUM_VREG = 8
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  vpu_pkg::opcode_e           opcode,
    input  logic [vpu_pkg::REG_AW-1:0] rd,
    input  logic [vpu_pkg::REG_AW-1:0] rs1,
    input  logic [vpu_pkg::REG_AW-1:0] rs2,
    input  logic [vpu_pkg::XLEN-1:0]   imm,
    input  logic                       v_step,
    input  logic [$clog2(MAX_VL)-1:0]  elem_idx,
    output logic [vpu_pkg::XLEN-1:0]   stream_data
);
    import vpu_pkg::*;

    localparam int VAW = $clog2(NUM_VREG);

    logic [XLEN-1:0] vreg [NUM_VREG][MAX_VL];
    logic [VAW-1:0]  vd;
    logic [VAW-1:0]  vs1;
    logic [VAW-1:0]  vs2;
    logic [XLEN-1:0] vd_elem;
    logic [XLEN-1:0] vs1_elem;
    logic [XLEN-1:0] vs2_elem;
    logic [XLEN-1:0] mac_sum;

    // register numbers above NUM_VREG alias down
    assign vd  = rd[VAW-1:0];
    assign vs1 = rs1[VAW-1:0];
    assign vs2 = rs2[VAW-1:0];

    assign vd_elem  = vreg[vd][elem_idx];
    assign vs1_elem = vreg[vs1][elem_idx];
    assign vs2_elem = vreg[vs2][elem_idx];

    assign mac_sum = vd_elem + vs1_elem * vs2_elem; // low XLEN bits of product

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int r = 0; r < NUM_VREG; r++) begin
                for (int e = 0; e < MAX_VL; e++) begin
                    vreg[r][e] <= '0;
                end
            end
        end else if (v_step) begin
            case (opcode)
                op_vmv_vi:   vreg[vd][elem_idx] <= imm; // splat
                op_vmacc_vv: vreg[vd][elem_idx] <= mac_sum;
                default:     ;
            endcase
        end
    end

    // for vstreamout rs2 holds the source register
    assign stream_data = vs2_elem;

endmodule

`default_nettype wire

// ==== rtl/scalar_unit/scalar_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

module scalar_unit (
    input  logic                       clk,
    input  logic                       rst_n,
    input  vpu_pkg::opcode_e           opcode,
    input  logic [vpu_pkg::REG_AW-1:0] rd,
    input  logic [vpu_pkg::REG_AW-1:0] rs1,
    input  logic [vpu_pkg::REG_AW-1:0] rs2,
    input  logic [vpu_pkg::XLEN-1:0]   imm,
    input  logic                       x_wen,
    output logic                       branch_taken
);
    import vpu_pkg::*;

    logic [XLEN-1:0] xreg [NUM_XREG];
    logic [XLEN-1:0] rs1_val;
    logic [XLEN-1:0] rs2_val;
    logic [XLEN-1:0] alu_out;

    // x0 is never written so it keeps its reset value
    assign rs1_val = xreg[rs1];
    assign rs2_val = xreg[rs2];

    always_comb begin
        case (opcode)
            op_lui:  alu_out = imm;
            op_addi: alu_out = rs1_val + imm;
            op_add:  alu_out = rs1_val + rs2_val;
            default: alu_out = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int r = 0; r < NUM_XREG; r++) begin
                xreg[r] <= '0;
            end
        end else if (x_wen && rd != '0) begin
            xreg[rd] <= alu_out;
        end
    end

    assign branch_taken = (opcode == op_bne) && (rs1_val != rs2_val);

endmodule

`default_nettype wire

// ==== rtl/elem_counter.sv ====
`timescale 1ns/10ps
`default_nettype none

module elem_counter #(
    parameter int MAX_VL = 8
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      vl_load,
    input  logic [4:0]                avl,
    input  logic                      v_step,
    output logic [$clog2(MAX_VL)-1:0] elem_idx,
    output logic                      last_elem
);
    localparam int IW = $clog2(MAX_VL);
    localparam int VW = IW + 1; // vl reaches MAX_VL

    logic [VW-1:0] vl;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vl       <= VW'(MAX_VL);
            elem_idx <= '0;
        end else if (vl_load) begin
            if (avl == 5'd0) vl <= VW'(1);
            else if (32'(avl) > MAX_VL) vl <= VW'(MAX_VL); // clamp high
            else vl <= VW'(avl);
            elem_idx <= '0;
        end else if (v_step) begin
            elem_idx <= last_elem ? '0 : elem_idx + 1'b1;
        end
    end

    assign last_elem = ({1'b0, elem_idx} == vl - VW'(1));

    a_idx_below_vl: assert property (@(posedge clk) disable iff (!rst_n)
        {1'b0, elem_idx} < vl);

endmodule

`default_nettype wire

// ==== rtl/core_ctrl.sv ====
`timescale 1ns/10ps
`default_nettype none

module core_ctrl (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     start,
    output logic                     done,
    output logic                     instr_req,
    output logic [vpu_pkg::PC_W-1:0] instr_addr,
    input  logic [vpu_pkg::ILEN-1:0] instr,
    input  logic                     instr_ack,
    output logic                     out_req,
    output logic [vpu_pkg::XLEN-1:0] out_data,
    input  logic                     out_ack,
    output logic [vpu_pkg::ILEN-1:0] ir,
    input  vpu_pkg::opcode_e         opcode,
    input  logic [vpu_pkg::PC_W-1:0] branch_off,
    input  logic                     branch_taken,
    input  logic                     last_elem,
    input  logic [vpu_pkg::XLEN-1:0] stream_data,
    output logic                     x_wen,
    output logic                     v_step,
    output logic                     vl_load
);
    import vpu_pkg::*;

    ctrl_state_e     state;
    logic [PC_W-1:0] pc;
    logic [PC_W-1:0] pc_next;

    assign pc_next = (opcode == op_bne && branch_taken) ? pc + branch_off : pc + PC_W'(4);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= st_idle;
            pc    <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (start) begin
                        pc    <= '0;
                        state <= st_fetch;
                    end
                end
                st_fetch:     if (instr_ack) state <= st_fetch_rel;
                st_fetch_rel: if (!instr_ack) state <= st_exec; // wait for ack low
                st_exec: begin
                    if (opcode != op_wfi) pc <= pc_next;
                    case (opcode)
                        op_wfi:                 state <= st_done;
                        op_vmv_vi, op_vmacc_vv: state <= st_vloop;
                        op_vstreamout:          state <= st_stream;
                        default:                state <= st_fetch;
                    endcase
                end
                st_vloop:  if (last_elem) state <= st_fetch;
                st_stream: if (out_ack) state <= st_stream_rel;
                st_stream_rel: begin
                    if (!out_ack) state <= last_elem ? st_fetch : st_stream;
                end
                st_done: if (!start) state <= st_idle;
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ir <= '0;
        end else if (state == st_fetch && instr_ack) begin
            ir <= instr;
        end
    end

    assign instr_req  = (state == st_fetch);
    assign instr_addr = pc;
    assign out_req    = (state == st_stream);
    assign out_data   = stream_data; // element under elem_idx of the source reg
    assign done       = (state == st_done);

    assign x_wen   = (state == st_exec) &&
                     (opcode == op_lui || opcode == op_addi || opcode == op_add);
    assign vl_load = (state == st_exec) && (opcode == op_vsetivli);
    // stream advances once the host has released ack
    assign v_step  = (state == st_vloop) || (state == st_stream_rel && !out_ack);

    a_instr_req_hold: assert property (@(posedge clk) disable iff (!rst_n)
        instr_req && !instr_ack |=> instr_req);

    // vector lane must not change the element under an open handshake
    a_out_data_stable: assert property (@(posedge clk) disable iff (!rst_n)
        out_req && !out_ack |=> out_req && $stable(out_data));

endmodule

`default_nettype wire

// ==== rtl/isa_decoder.sv ====
`timescale 1ns/10ps
`default_nettype none

module isa_decoder (
    input  logic [vpu_pkg::ILEN-1:0]   instr,
    output vpu_pkg::opcode_e           opcode,
    output logic [vpu_pkg::REG_AW-1:0] rd,
    output logic [vpu_pkg::REG_AW-1:0] rs1,
    output logic [vpu_pkg::REG_AW-1:0] rs2,
    output logic [vpu_pkg::XLEN-1:0]   imm,
    output logic [vpu_pkg::PC_W-1:0]   branch_off
);
    import vpu_pkg::*;

    logic [6:0] major;
    logic [2:0] funct3;
    logic [6:0] funct7;

    assign major  = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    always_comb begin
        opcode = op_nop; // loads, stores, csr and anything unknown
        case (major)
            OPC_LUI: opcode = op_lui;
            OPC_OP_IMM: begin
                if (funct3 == F3_ADDI) opcode = op_addi;
            end
            OPC_OP: begin
                if (funct3 == F3_ADD && funct7 == F7_ADD) opcode = op_add;
            end
            OPC_BRANCH: begin
                if (funct3 == F3_BNE) opcode = op_bne;
            end
            OPC_VECTOR: begin
                case (funct3)
                    F3_VMACC:    opcode = op_vmacc_vv;
                    F3_VMV_VI:   opcode = op_vmv_vi;
                    F3_VSETIVLI: opcode = op_vsetivli;
                    default:     opcode = op_nop;
                endcase
            end
            OPC_VSTREAM: opcode = op_vstreamout;
            OPC_SYSTEM: begin
                if (instr == INSTR_WFI) opcode = op_wfi; // other system ops ignored
            end
            default: opcode = op_nop;
        endcase
    end

    // register fields
    assign rd  = instr[11:7];
    assign rs1 = instr[19:15]; // vs1 for vector ops
    // vstreamout names its source in the rd slot
    assign rs2 = (opcode == op_vstreamout) ? instr[11:7] : instr[24:20];

    always_comb begin
        case (opcode)
            op_lui:      imm = {instr[31:12], 12'b0};
            op_vmv_vi:   imm = {{(XLEN-5){instr[19]}}, instr[19:15]}; // simm5
            op_vsetivli: imm = {{(XLEN-5){1'b0}}, instr[19:15]};      // avl
            default:     imm = {{(XLEN-12){instr[31]}}, instr[31:20]}; // i-type
        endcase
    end

    // b-type offset, bit 0 always zero
    assign branch_off = PC_W'({instr[31], instr[7], instr[30:25], instr[11:8], 1'b0});

endmodule

`default_nettype wire

// ==== common/vpu_pkg.sv ====
`default_nettype none

package vpu_pkg;

    parameter int XLEN     = 32;
    parameter int ILEN     = 32;
    parameter int NUM_XREG = 32; // x0 reads as zero
    parameter int REG_AW   = 5;
    parameter int PC_W     = 12; // byte address

    typedef enum logic [3:0] {
        op_nop,
        op_lui,
        op_addi,
        op_add,
        op_bne,
        op_vsetivli,
        op_vmv_vi,
        op_vmacc_vv,
        op_vstreamout,
        op_wfi
    } opcode_e;

    typedef enum logic [2:0] {
        st_idle,
        st_fetch,
        st_fetch_rel,
        st_exec,
        st_vloop,
        st_stream,
        st_stream_rel,
        st_done
    } ctrl_state_e;

    // major opcodes
    parameter logic [6:0] OPC_LUI     = 7'b0110111;
    parameter logic [6:0] OPC_OP_IMM  = 7'b0010011;
    parameter logic [6:0] OPC_OP      = 7'b0110011;
    parameter logic [6:0] OPC_BRANCH  = 7'b1100011;
    parameter logic [6:0] OPC_SYSTEM  = 7'b1110011;
    parameter logic [6:0] OPC_VECTOR  = 7'h57;
    parameter logic [6:0] OPC_VSTREAM = 7'h7f; // custom extension

    // funct3 and funct7 values
    parameter logic [2:0] F3_ADDI     = 3'b000;
    parameter logic [2:0] F3_ADD      = 3'b000;
    parameter logic [6:0] F7_ADD      = 7'b0000000;
    parameter logic [2:0] F3_BNE      = 3'b001;
    parameter logic [2:0] F3_VMACC    = 3'h0;
    parameter logic [2:0] F3_VMV_VI   = 3'h5;
    parameter logic [2:0] F3_VSETIVLI = 3'h7;

    parameter logic [31:0] INSTR_WFI  = 32'h1050_0073;

endpackage

`default_nettype wire
